// File: list.f
verilog/accel_pkg.sv
verilog/baud_timer.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/matmul_tile.sv
verilog/accel_ctrl.sv
verilog/systolic_top.sv
verification/tb_clock_gen.sv
verification/systolic_top_asserts.sv
verification/tb_top.sv

// File: verification/tb_top.sv
module tb_top
    import accel_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES     = 216 * 10 * BIT_CYCLES + 200;
    localparam int WATCHDOG_CYCLES = 2 * 6 * TEST_CYCLES;
    localparam int RESULT_ELEMS    = NUM_TILES * MAT_ELEMS;

    logic    clk_in;
    logic    rst_in;
    logic    start;
    opcode_t opcode;
    logic    rx_line;
    logic    tx_line;
    logic    busy;
    logic    done;

    logic [7:0]  a_bytes [LOAD_BYTES];
    logic [7:0]  b_bytes [LOAD_BYTES];
    q_t          got [RESULT_ELEMS];
    logic [31:0] rng;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          done_count = 0;

    tb_clock_gen u_clk (
        .o_clk (clk_in),
        .o_rst (rst_in)
    );

    systolic_top UUT (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .i_start  (start),
        .i_opcode (opcode),
        .i_rx     (rx_line),
        .o_tx     (tx_line),
        .o_busy   (busy),
        .o_done   (done)
    );

    always @(negedge clk_in) begin
        if (done === 1'b1)
            done_count <= done_count + 1;
    end

    // --------------------
    // Stimulus
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Narrow mode keeps bytes in -3..3 so sums straddle the sigmoid steps
    function automatic logic [7:0] next_byte(input bit narrow);
        int v;
        rng = lcg_next(rng);
        v = int'(rng[23:16] % 8'd7) - 3;
        return narrow ? v[7:0] : rng[23:16];
    endfunction

    task automatic fill_operands(input bit narrow);
        for (int n = 0; n < LOAD_BYTES; n++) begin
            a_bytes[n] = next_byte(narrow);
            b_bytes[n] = next_byte(narrow);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int n = 0; n < 10; n++) begin
            rx_line = frame[n];
            repeat (BIT_CYCLES) @(negedge clk_in);
        end
    endtask

    task automatic start_job(input opcode_t op);
        @(negedge clk_in);
        opcode = op;
        start  = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk_in);
        checks++;
        assert (busy === 1'b1) else begin
            $display("Busy did not rise after start with opcode %0d", op);
            errors++;
        end
        start = 1'b0;
    endtask

    // A negative index means no second start during the job
    task automatic send_operands(input int retrig_at);
        for (int n = 0; n < 2 * LOAD_BYTES; n++) begin
            if (n == retrig_at) begin
                opcode = 4'd5;
                start  = 1'b1;
                @(negedge clk_in);
                start = 1'b0;
            end
            send_byte(n < LOAD_BYTES ? a_bytes[n] : b_bytes[n - LOAD_BYTES]);
        end
    endtask

    task automatic receive_byte(output logic [7:0] b);
        while (tx_line !== 1'b0)
            @(negedge clk_in);
        // Move to the middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge clk_in);
        for (int n = 0; n < 8; n++) begin
            repeat (BIT_CYCLES) @(negedge clk_in);
            b[n] = tx_line;
        end
        repeat (BIT_CYCLES) @(negedge clk_in);
        checks++;
        assert (tx_line === 1'b1) else begin
            $display("Stop bit missing on the transmit line");
            errors++;
        end
    endtask

    // Elements arrive least significant byte first
    task automatic receive_results();
        logic [7:0] b;
        for (int idx = 0; idx < RESULT_ELEMS; idx++) begin
            for (int n = 0; n < 4; n++) begin
                receive_byte(b);
                got[idx][8*n +: 8] = b;
            end
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Integer operands carry a zero fraction, so only the low byte of the
    // integer dot product survives as the integer part of the sum
    function automatic q_t expected_elem(input opcode_t op, input int idx);
        int                t;
        int                i;
        int                j;
        int                dot;
        logic signed [7:0] ip;
        q_t                sum;
        t   = idx / MAT_ELEMS;
        i   = (idx % MAT_ELEMS) / MAT_DIM;
        j   = (idx % MAT_ELEMS) % MAT_DIM;
        dot = 0;
        for (int k = 0; k < MAT_DIM; k++) begin
            dot += int'($signed(a_bytes[t*MAT_ELEMS + i*MAT_DIM + k]))
                 * int'($signed(b_bytes[t*MAT_ELEMS + k*MAT_DIM + j]));
        end
        ip  = dot[7:0];
        sum = {ip, 24'h0};
        case (op)
            OP_MATMUL: return sum;
            OP_RELU:   return (ip < 0) ? q_t'(0) : sum;
            OP_LEAKY:  return (ip < 0) ? q_t'(int'(ip) * Q_TENTH) : sum;
            OP_SIGMOID: begin
                if (ip >= 4)
                    return 32'sh0100_0000;
                else if (ip <= -4)
                    return q_t'(0);
                else
                    return 32'sh0080_0000;
            end
            default:   return q_t'(0);
        endcase
    endfunction

    task automatic check_results(input string name, input opcode_t op);
        q_t want;
        for (int idx = 0; idx < RESULT_ELEMS; idx++) begin
            want = expected_elem(op, idx);
            checks++;
            assert (got[idx] === want) else begin
                $display("MISMATCH %s element %0d expected %h actual %h",
                         name, idx, want, got[idx]);
                errors++;
            end
        end
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_count < target && n < 20 * BIT_CYCLES) begin
            @(negedge clk_in);
            n++;
        end
        checks++;
        assert (done_count == target) else begin
            $display("Done pulse missing after the last result byte");
            errors++;
        end
    endtask

    task automatic run_test(input string name, input opcode_t op, input bit narrow,
                            input int retrig_at);
        int errors_before;
        int dones;
        errors_before = errors;
        dones         = done_count;
        fill_operands(narrow);
        start_job(op);
        fork
            send_operands(retrig_at);
            receive_results();
        join
        wait_done(dones + 1);
        check_results(name, op);
        if (retrig_at >= 0) begin
            repeat (20 * BIT_CYCLES) @(negedge clk_in);
            checks++;
            assert (done_count == dones + 1 && busy === 1'b0) else begin
                $display("Second start during a job began another job");
                errors++;
            end
        end
        repeat (2 * BIT_CYCLES) @(negedge clk_in);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        start   = 1'b0;
        opcode  = '0;
        rx_line = 1'b1;
        rng     = 32'h377b;
        @(negedge rst_in);
        repeat (4) @(negedge clk_in);
        run_test("matmul", OP_MATMUL, 1'b0, -1);
        run_test("relu", OP_RELU, 1'b0, -1);
        run_test("leaky_relu", OP_LEAKY, 1'b0, -1);
        run_test("sigmoid", OP_SIGMOID, 1'b1, -1);
        run_test("unknown_opcode", 4'd5, 1'b0, -1);
        run_test("restart_ignored", OP_MATMUL, 1'b0, 10);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Watchdog expired before all tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verification/systolic_top_asserts.sv
module systolic_top_asserts (
    input logic clk_in,
    input logic rst_in,
    input logic i_busy,
    input logic i_done,
    input logic i_tx
);
    timeunit 1ns;
    timeprecision 1ps;

    // Done closes the job in the same cycle busy drops
    a_done_ends_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        i_done |-> !i_busy && $past(i_busy))
    else $error("done pulse without busy falling in the same cycle");

    a_done_single: assert property (@(posedge clk_in) disable iff (rst_in)
        i_done |=> !i_done)
    else $error("done pulse longer than one cycle");

    // Line idles high between jobs
    a_tx_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        !i_busy |-> i_tx)
    else $error("transmit line low while not busy");

endmodule

bind systolic_top systolic_top_asserts u_asserts (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .i_busy (o_busy),
    .i_done (o_done),
    .i_tx   (o_tx)
);

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (8) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// File: verilog/systolic_top.sv
module systolic_top
    import accel_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,
    input  logic    i_start,
    input  opcode_t i_opcode,
    input  logic    i_rx,
    output logic    o_tx,
    output logic    o_busy,
    output logic    o_done
);

    logic [7:0]                     rx_byte;
    logic                           rx_valid;
    logic                           tx_strobe;
    logic [7:0]                     tx_byte;
    logic                           tx_ready;
    logic                           tile_start;
    logic                           tile_done;
    opcode_t                        tile_opcode;
    tile_operands_t [NUM_TILES-1:0] operands;
    matrix_t [NUM_TILES-1:0]        results;

    // --------------------
    // Serial link
    // --------------------
    uart_rx u_rx (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .i_rx         (i_rx),
        .o_byte       (rx_byte),
        .o_byte_valid (rx_valid)
    );

    uart_tx u_tx (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .i_strobe (tx_strobe),
        .i_byte   (tx_byte),
        .o_tx     (o_tx),
        .o_ready  (tx_ready)
    );

    accel_ctrl u_ctrl (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .i_start       (i_start),
        .i_opcode      (i_opcode),
        .i_rx_byte     (rx_byte),
        .i_rx_valid    (rx_valid),
        .i_tx_ready    (tx_ready),
        .i_tile_done   (tile_done),
        .i_tile_result (results),
        .o_tile_start  (tile_start),
        .o_opcode      (tile_opcode),
        .o_operands    (operands),
        .o_tx_strobe   (tx_strobe),
        .o_tx_byte     (tx_byte),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    // --------------------
    // Tiles
    // --------------------
    // Lockstep tiles, only tile 0 reports completion
    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        if (t == 0) begin : g_lead
            matmul_tile u_tile (
                .clk_in     (clk_in),
                .rst_in     (rst_in),
                .i_start    (tile_start),
                .i_opcode   (tile_opcode),
                .i_operands (operands[t]),
                .o_result   (results[t]),
                .o_done     (tile_done)
            );
        end else begin : g_follow
            matmul_tile u_tile (
                .clk_in     (clk_in),
                .rst_in     (rst_in),
                .i_start    (tile_start),
                .i_opcode   (tile_opcode),
                .i_operands (operands[t]),
                .o_result   (results[t]),
                .o_done     ()
            );
        end
    end

endmodule

// File: verilog/accel_ctrl.sv
module accel_ctrl
    import accel_pkg::*;
(
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            i_start,
    input  opcode_t                         i_opcode,
    input  logic [7:0]                      i_rx_byte,
    input  logic                            i_rx_valid,
    input  logic                            i_tx_ready,
    input  logic                            i_tile_done,
    input  matrix_t [NUM_TILES-1:0]         i_tile_result,
    output logic                            o_tile_start,
    output opcode_t                         o_opcode,
    output tile_operands_t [NUM_TILES-1:0]  o_operands,
    output logic                            o_tx_strobe,
    output logic [7:0]                      o_tx_byte,
    output logic                            o_busy,
    output logic                            o_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_A,
        S_LOAD_B,
        S_RUN,
        S_SEND_C
    } ctrl_state_t;

    ctrl_state_t state;
    logic [7:0]  byte_cnt;

    // Flat element store, index tile*9 + element
    q_t [NUM_TILES*MAT_ELEMS-1:0] a_q;
    q_t [NUM_TILES*MAT_ELEMS-1:0] b_q;
    q_t [NUM_TILES*MAT_ELEMS-1:0] c_q;

    logic load_last;
    logic send_now;
    logic send_done;

    assign load_last = (byte_cnt == 8'(LOAD_BYTES - 1));
    // Skip the cycle right after a strobe, ready has not dropped yet
    assign send_now  = (state == S_SEND_C) && (byte_cnt != 8'(RESULT_BYTES))
                       && i_tx_ready && !o_tx_strobe;
    assign send_done = (state == S_SEND_C) && (byte_cnt == 8'(RESULT_BYTES))
                       && i_tx_ready && !o_tx_strobe;

    always_comb begin
        for (int t = 0; t < NUM_TILES; t++) begin
            o_operands[t].a = a_q[t*MAT_ELEMS +: MAT_ELEMS];
            o_operands[t].b = b_q[t*MAT_ELEMS +: MAT_ELEMS];
        end
    end

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state        <= S_IDLE;
            byte_cnt     <= '0;
            o_opcode     <= '0;
            o_tile_start <= 1'b0;
            o_tx_strobe  <= 1'b0;
            o_busy       <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            o_tile_start <= 1'b0;
            o_tx_strobe  <= send_now;
            o_done       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state    <= S_LOAD_A;
                        o_busy   <= 1'b1;
                        o_opcode <= i_opcode;
                        byte_cnt <= '0;
                    end
                end
                S_LOAD_A: begin
                    if (i_rx_valid) begin
                        byte_cnt <= load_last ? 8'd0 : byte_cnt + 8'd1;
                        if (load_last)
                            state <= S_LOAD_B;
                    end
                end
                S_LOAD_B: begin
                    if (i_rx_valid) begin
                        byte_cnt <= load_last ? 8'd0 : byte_cnt + 8'd1;
                        if (load_last) begin
                            state        <= S_RUN;
                            o_tile_start <= 1'b1;
                        end
                    end
                end
                S_RUN: begin
                    if (i_tile_done)
                        state <= S_SEND_C;
                end
                S_SEND_C: begin
                    if (send_now) begin
                        byte_cnt <= byte_cnt + 8'd1;
                    end else if (send_done) begin
                        state  <= S_IDLE;
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // --------------------
    // Operand and result storage
    // --------------------
    always_ff @(posedge clk_in) begin
        // Received byte is the signed integer part
        if (state == S_LOAD_A && i_rx_valid)
            a_q[byte_cnt[5:0]] <= {i_rx_byte, {Q_FRAC_BITS{1'b0}}};
        if (state == S_LOAD_B && i_rx_valid)
            b_q[byte_cnt[5:0]] <= {i_rx_byte, {Q_FRAC_BITS{1'b0}}};
        if (state == S_RUN && i_tile_done)
            c_q <= i_tile_result;
        // Four bytes per element, LSB first
        if (send_now)
            o_tx_byte <= c_q[byte_cnt[7:2]][8*byte_cnt[1:0] +: 8];
    end

endmodule

// File: verilog/matmul_tile.sv
module matmul_tile
    import accel_pkg::*;
(
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           i_start,
    input  opcode_t        i_opcode,
    input  tile_operands_t i_operands,
    output matrix_t        o_result,
    output logic           o_done
);

    typedef enum logic [1:0] {
        T_IDLE,
        T_ACC,
        T_ACT
    } tile_state_t;

    tile_state_t state;
    logic [1:0]  k;
    matrix_t     acc;

    // --------------------
    // Sequencing
    // --------------------
    // Three accumulate cycles then one activation cycle, for every opcode
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state  <= T_IDLE;
            k      <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                state <= T_ACC;
                k     <= '0;
            end else begin
                case (state)
                    T_ACC: begin
                        k <= k + 2'd1;
                        if (k == 2'(MAT_DIM - 1))
                            state <= T_ACT;
                    end
                    T_ACT: begin
                        o_done <= 1'b1;
                        state  <= T_IDLE;
                    end
                    default: state <= T_IDLE;
                endcase
            end
        end
    end

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clk_in) begin
        if (i_start) begin
            acc <= '0;
        end else if (state == T_ACC && op_known(i_opcode)) begin
            // C[i][j] += A[i][k] * B[k][j]
            for (int i = 0; i < MAT_DIM; i++) begin
                for (int j = 0; j < MAT_DIM; j++) begin
                    acc.e[i*MAT_DIM+j] <= acc.e[i*MAT_DIM+j]
                        + q_mul(i_operands.a.e[i*MAT_DIM+k], i_operands.b.e[k*MAT_DIM+j]);
                end
            end
        end else if (state == T_ACT) begin
            for (int e = 0; e < MAT_ELEMS; e++) begin
                o_result.e[e] <= op_known(i_opcode) ? q_activate(i_opcode, acc.e[e]) : q_t'(0);
            end
        end
    end

endmodule

// File: verilog/uart_tx.sv
module uart_tx (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       i_strobe,
    input  logic [7:0] i_byte,
    output logic       o_tx,
    output logic       o_ready
);

    logic       active;
    logic [3:0] bit_idx;
    logic [7:0] shift_q;
    logic       tx_q;
    logic       bit_end;

    baud_timer u_timer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .i_run     (active),
        .o_mid     (),
        .o_bit_end (bit_end)
    );

    // --------------------
    // Frame sequencing
    // --------------------
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            active  <= 1'b0;
            bit_idx <= '0;
            tx_q    <= 1'b1;
        end else if (!active) begin
            bit_idx <= '0;
            if (i_strobe) begin
                active <= 1'b1;
                tx_q   <= 1'b0;
            end
        end else if (bit_end) begin
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx < 4'd8)
                tx_q <= shift_q[0];
            else if (bit_idx == 4'd8)
                tx_q <= 1'b1;
            else
                active <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!active && i_strobe)
            shift_q <= i_byte;
        else if (active && bit_end)
            shift_q <= shift_q >> 1;
    end

    assign o_tx    = tx_q;
    assign o_ready = !active;

endmodule

// File: verilog/uart_rx.sv
module uart_rx (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_byte_valid
);

    logic [1:0] rx_sync;
    logic       active;
    logic [3:0] bit_idx;
    logic [7:0] shift_q;
    logic       mid;
    logic       bit_end;

    baud_timer u_timer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .i_run     (active),
        .o_mid     (mid),
        .o_bit_end (bit_end)
    );

    // Bit 0 is the start bit, 1..8 data, 9 stop
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rx_sync      <= 2'b11;
            active       <= 1'b0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            rx_sync      <= {rx_sync[0], i_rx};
            o_byte_valid <= 1'b0;
            if (!active) begin
                bit_idx <= '0;
                if (!rx_sync[1])
                    active <= 1'b1;
            end else begin
                if (mid && bit_idx == 4'd0 && rx_sync[1]) begin
                    // Glitch, not a real start bit
                    active <= 1'b0;
                end else if (mid && bit_idx == 4'd9) begin
                    active       <= 1'b0;
                    o_byte_valid <= rx_sync[1];
                end
                if (bit_end)
                    bit_idx <= bit_idx + 4'd1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_in) begin
        if (active && mid && bit_idx >= 4'd1 && bit_idx <= 4'd8)
            shift_q <= {rx_sync[1], shift_q[7:1]};
    end

    assign o_byte = shift_q;

endmodule

// File: verilog/baud_timer.sv
module baud_timer
    import accel_pkg::*;
(
    input  logic clk_in,
    input  logic rst_in,
    input  logic i_run,
    output logic o_mid,
    output logic o_bit_end
);

    logic [3:0] cnt;

    // Held at zero while idle so each frame starts on a clean bit boundary
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cnt <= '0;
        end else if (!i_run) begin
            cnt <= '0;
        end else if (cnt == 4'(BIT_CYCLES - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 4'd1;
        end
    end

    assign o_mid     = i_run && (cnt == 4'(BIT_CYCLES / 2));
    assign o_bit_end = i_run && (cnt == 4'(BIT_CYCLES - 1));

endmodule

// File: verilog/accel_pkg.sv
package accel_pkg;

    // --------------------
    // Q8.24 types
    // --------------------
    typedef logic signed [31:0] q_t;

    // Row-major 3x3 block, element i*3+j
    typedef struct packed {
        q_t [8:0] e;
    } matrix_t;

    typedef struct packed {
        matrix_t a;
        matrix_t b;
    } tile_operands_t;

    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_MATMUL  = 4'd1;
    localparam opcode_t OP_RELU    = 4'd2;
    localparam opcode_t OP_LEAKY   = 4'd3;
    localparam opcode_t OP_SIGMOID = 4'd10;

    localparam int Q_FRAC_BITS = 24;
    localparam q_t Q_ONE       = 32'sh0100_0000;
    localparam q_t Q_HALF      = 32'sh0080_0000;
    localparam q_t Q_TENTH     = 32'sd1677722;

    localparam int MAT_DIM      = 3;
    localparam int MAT_ELEMS    = 9;
    localparam int NUM_TILES    = 4;
    localparam int LOAD_BYTES   = 36;
    localparam int RESULT_BYTES = 144;

    // Clock cycles per UART bit
    localparam int BIT_CYCLES = 11;

    // --------------------
    // Arithmetic
    // --------------------
    function automatic q_t q_mul(q_t a, q_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return q_t'(prod >>> Q_FRAC_BITS);
    endfunction

    function automatic logic op_known(opcode_t op);
        return op inside {OP_MATMUL, OP_RELU, OP_LEAKY, OP_SIGMOID};
    endfunction

    function automatic q_t q_activate(opcode_t op, q_t x);
        logic signed [7:0] int_part;
        int_part = x[31:Q_FRAC_BITS];
        case (op)
            OP_RELU:    q_activate = (x < 0) ? q_t'(0) : x;
            OP_LEAKY:   q_activate = (x < 0) ? q_mul(x, Q_TENTH) : x;
            // Coarse step approximation of the sigmoid
            OP_SIGMOID: begin
                if (int_part >= 4)
                    q_activate = Q_ONE;
                else if (int_part <= -4)
                    q_activate = q_t'(0);
                else
                    q_activate = Q_HALF;
            end
            default:    q_activate = x;
        endcase
    endfunction

endpackage
